// File: sf_ops.svh
`ifndef SF_OPS_SVH
`define SF_OPS_SVH
// filter program, one word per pc value
// an instruction at pc p may read any register written at pc p-1 or earlier
// fields: op, dst, src a, src b, out select, sample as src b

// samples m0..m4 into r0..r4
7'd0: rom_d = sf_pkg::mk_inst(sf_pkg::OP_LOAD, 3'd0, 3'd0, 3'd0, 2'd0, 1'b0);
7'd1: rom_d = sf_pkg::mk_inst(sf_pkg::OP_LOAD, 3'd1, 3'd0, 3'd0, 2'd0, 1'b0);
7'd2: rom_d = sf_pkg::mk_inst(sf_pkg::OP_LOAD, 3'd2, 3'd0, 3'd0, 2'd0, 1'b0);
7'd3: rom_d = sf_pkg::mk_inst(sf_pkg::OP_LOAD, 3'd3, 3'd0, 3'd0, 2'd0, 1'b0);
7'd4: rom_d = sf_pkg::mk_inst(sf_pkg::OP_LOAD, 3'd4, 3'd0, 3'd0, 2'd0, 1'b0);
// t = m4 + m5 lands in r5, m5 is used straight off the sample
7'd5: rom_d = sf_pkg::mk_inst(sf_pkg::OP_ADD, 3'd5, 3'd4, 3'd0, 2'd0, 1'b1);
// constant window, each constant consumed as it arrives
// r6 = mul(m0, k0)
7'd6: rom_d = sf_pkg::mk_inst(sf_pkg::OP_MUL, 3'd6, 3'd0, 3'd0, 2'd0, 1'b1);
// r7 = mul(m4, k1), last use of m4
7'd7: rom_d = sf_pkg::mk_inst(sf_pkg::OP_MUL, 3'd7, 3'd4, 3'd0, 2'd0, 1'b1);
// r4 = mul(t, k2), m4 is free now
7'd8: rom_d = sf_pkg::mk_inst(sf_pkg::OP_MUL, 3'd4, 3'd5, 3'd0, 2'd0, 1'b1);
// r5 = r4 - k3
7'd9: rom_d = sf_pkg::mk_inst(sf_pkg::OP_SUB, 3'd5, 3'd4, 3'd0, 2'd0, 1'b1);
// r6 = mul(m0, k0) + m1
7'd10: rom_d = sf_pkg::mk_inst(sf_pkg::OP_ADD, 3'd6, 3'd6, 3'd1, 2'd0, 1'b0);
// r2 = m2 - m3
7'd11: rom_d = sf_pkg::mk_inst(sf_pkg::OP_SUB, 3'd2, 3'd2, 3'd3, 2'd0, 1'b0);
// results a, b, c, d
7'd12: rom_d = sf_pkg::mk_inst(sf_pkg::OP_OUT, 3'd0, 3'd6, 3'd0, 2'd0, 1'b0);
7'd13: rom_d = sf_pkg::mk_inst(sf_pkg::OP_OUT, 3'd0, 3'd2, 3'd0, 2'd1, 1'b0);
7'd14: rom_d = sf_pkg::mk_inst(sf_pkg::OP_OUT, 3'd0, 3'd7, 3'd0, 2'd2, 1'b0);
7'd15: rom_d = sf_pkg::mk_inst(sf_pkg::OP_OUT, 3'd0, 3'd5, 3'd0, 2'd3, 1'b0);
// idle for the rest of the pass
default: rom_d = sf_pkg::mk_inst(sf_pkg::OP_NOP, 3'd0, 3'd0, 3'd0, 2'd0, 1'b0);
`endif

// File: sf_pkg.sv
package sf_pkg;

	// instruction field widths
	localparam int OP_W = 3;
	localparam int REG_AW = 3;
	localparam int SEL_W = 2;
	localparam int INST_W = 21;
	localparam int PC_W = 7;

	// engine opcodes
	typedef enum logic [OP_W-1:0] {
		OP_NOP = 3'd0,
		OP_LOAD = 3'd1,
		OP_MUL = 3'd2,
		OP_ADD = 3'd3,
		OP_SUB = 3'd4,
		OP_OUT = 3'd5
	} sf_op_e;

	// field positions, msb first: op, dst, src a, src b, out select
	localparam int OP_LSB = 18;
	localparam int DST_LSB = 15;
	localparam int SRCA_LSB = 12;
	localparam int SRCB_LSB = 9;
	localparam int SEL_LSB = 7;
	// first of the spare bits, marks source b as the incoming sample
	localparam int SMP_BIT = 6;

	// pack one instruction word
	function automatic logic [INST_W-1:0] mk_inst(
		input sf_op_e op,
		input logic [REG_AW-1:0] dst,
		input logic [REG_AW-1:0] src_a,
		input logic [REG_AW-1:0] src_b,
		input logic [SEL_W-1:0] sel,
		input logic smp
	);
		return {op, dst, src_a, src_b, sel, smp, {SMP_BIT{1'b0}}};
	endfunction

endpackage

// File: sf_const_ram.sv
`timescale 1ns/1ps

module sf_const_ram #(
	parameter int pw = 18,
	parameter int const_aw = 2
) (
	input logic clk,
	input logic rst_i,
	// host write side, not tied to ce
	input logic host_we_i,
	input logic [const_aw-1:0] host_addr_i,
	input logic signed [pw-1:0] host_data_i,
	// sequencer read side
	input logic ce_i,
	input logic [const_aw-1:0] rd_addr_i,
	output logic signed [pw-1:0] rd_data_o
);

	// constant storage
	logic signed [pw-1:0] mem [0:2**const_aw-1];

	// host write lands on this edge
	always_ff @(posedge clk) begin
		if (host_we_i) begin
			mem[host_addr_i] <= host_data_i;
		end
	end

	// registered read, one ce cycle of latency
	always_ff @(posedge clk) begin
		if (rst_i) begin
			rd_data_o <= '0;
		end else if (ce_i) begin
			rd_data_o <= mem[rd_addr_i];
		end
	end

endmodule

// File: sf_engine.sv
`timescale 1ns/1ps

module sf_engine #(
	parameter int pw = 18,
	parameter int extra = 4,
	parameter int mw = 18
) (
	input logic clk,
	input logic rst_i,
	input logic ce_i,
	input logic [sf_pkg::INST_W-1:0] inst_i,
	input logic signed [pw-1:0] meas_i,
	output logic signed [pw-1:0] a_o,
	output logic signed [pw-1:0] b_o,
	output logic signed [pw-1:0] c_o,
	output logic signed [pw-1:0] d_o,
	output logic signed [pw+extra-1:0] trace_o,
	output logic sat_happened_o
);

	// register width
	localparam int rw = pw + extra;
	// working width, wide enough for any product or sum before clipping
	localparam int xw = 2 * mw + rw;

	// clip v into the n-bit signed range
	function automatic logic signed [xw-1:0] clip(input logic signed [xw-1:0] v, input int n);
		logic signed [xw-1:0] hi;
		logic signed [xw-1:0] lo;
		hi = (xw'(1) <<< (n - 1)) - 1;
		lo = -hi - 1;
		if (v > hi) begin
			return hi;
		end else if (v < lo) begin
			return lo;
		end
		return v;
	endfunction

	// decoded fields
	sf_pkg::sf_op_e op;
	logic [sf_pkg::REG_AW-1:0] dst;
	logic [sf_pkg::REG_AW-1:0] src_a;
	logic [sf_pkg::REG_AW-1:0] src_b;
	logic [sf_pkg::SEL_W-1:0] sel;
	logic use_smp;

	assign op = sf_pkg::sf_op_e'(inst_i[sf_pkg::OP_LSB +: sf_pkg::OP_W]);
	assign dst = inst_i[sf_pkg::DST_LSB +: sf_pkg::REG_AW];
	assign src_a = inst_i[sf_pkg::SRCA_LSB +: sf_pkg::REG_AW];
	assign src_b = inst_i[sf_pkg::SRCB_LSB +: sf_pkg::REG_AW];
	assign sel = inst_i[sf_pkg::SEL_LSB +: sf_pkg::SEL_W];
	assign use_smp = inst_i[sf_pkg::SMP_BIT];

	// register file
	logic signed [rw-1:0] rf [0:2**sf_pkg::REG_AW-1];

	// operands, sign extended to the working width
	logic signed [xw-1:0] opa;
	logic signed [xw-1:0] opb;
	logic signed [xw-1:0] ma;
	logic signed [xw-1:0] mb;
	logic signed [xw-1:0] prod;
	logic signed [xw-1:0] wide;
	logic signed [xw-1:0] res;
	logic signed [xw-1:0] out_v;
	logic writes_reg;
	logic clipped;

	assign opa = xw'(rf[src_a]);
	// source b may come straight from the sample register
	assign opb = use_smp ? xw'(meas_i) : xw'(rf[src_b]);

	always_comb begin
		// multiplier inputs limited to mw bits
		ma = clip(opa, mw);
		mb = clip(opb, mw);
		// fractional product, drop the duplicated sign
		prod = (ma * mb) >>> (mw - 1);
		wide = '0;
		writes_reg = 1'b0;
		case (op)
			sf_pkg::OP_LOAD: begin
				wide = xw'(meas_i);
				writes_reg = 1'b1;
			end
			sf_pkg::OP_MUL: begin
				wide = prod;
				writes_reg = 1'b1;
			end
			sf_pkg::OP_ADD: begin
				wide = opa + opb;
				writes_reg = 1'b1;
			end
			sf_pkg::OP_SUB: begin
				wide = opa - opb;
				writes_reg = 1'b1;
			end
			default: begin
				wide = '0;
			end
		endcase
		res = clip(wide, rw);
		// results are pw wide
		out_v = clip(opa, pw);
		// one flag per cycle, however many stages clipped
		case (op)
			sf_pkg::OP_MUL: clipped = (ma != opa) || (mb != opb) || (res != wide);
			sf_pkg::OP_ADD: clipped = res != wide;
			sf_pkg::OP_SUB: clipped = res != wide;
			sf_pkg::OP_OUT: clipped = out_v != opa;
			default: clipped = 1'b0;
		endcase
	end

	assign sat_happened_o = clipped;

	// register writeback
	always_ff @(posedge clk) begin
		if (ce_i && writes_reg) begin
			rf[dst] <= res[rw-1:0];
		end
	end

	// trace and result registers
	always_ff @(posedge clk) begin
		if (rst_i) begin
			trace_o <= '0;
			a_o <= '0;
			b_o <= '0;
			c_o <= '0;
			d_o <= '0;
		end else if (ce_i) begin
			// trace follows the last register write
			if (writes_reg) begin
				trace_o <= res[rw-1:0];
			end
			if (op == sf_pkg::OP_OUT) begin
				case (sel)
					2'd0: a_o <= out_v[pw-1:0];
					2'd1: b_o <= out_v[pw-1:0];
					2'd2: c_o <= out_v[pw-1:0];
					default: d_o <= out_v[pw-1:0];
				endcase
			end
		end
	end

	// the ROM leaves dst at zero on result copies, so decode never mixes the two
	a_out_no_dst: assert property (@(posedge clk) disable iff (rst_i)
		(ce_i && op == sf_pkg::OP_OUT) |-> (dst == '0));

endmodule

// File: sf_sequencer.sv
`timescale 1ns/1ps

module sf_sequencer #(
	parameter int pw = 18,
	parameter int extra = 4,
	parameter int mw = 18,
	parameter int data_len = 6,
	parameter int consts_len = 4,
	parameter int const_aw = 2
) (
	input logic clk,
	input logic rst_i,
	input logic ce_i,
	input logic signed [pw-1:0] meas_i,
	input logic trigger_i,
	// constant memory read port
	input logic signed [pw-1:0] const_data_i,
	output logic [const_aw-1:0] const_addr_o,
	output logic signed [pw-1:0] a_o,
	output logic signed [pw-1:0] b_o,
	output logic signed [pw-1:0] c_o,
	output logic signed [pw-1:0] d_o,
	// debug stream
	output logic signed [pw+extra-1:0] trace_o,
	output logic [sf_pkg::PC_W-1:0] trace_addr_o,
	output logic trace_strobe_o,
	output logic [6:0] sat_count_o
);

	// constant window bounds in pc terms
	localparam logic [sf_pkg::PC_W-1:0] CONST_LO = sf_pkg::PC_W'(data_len);
	localparam logic [sf_pkg::PC_W-1:0] CONST_HI = sf_pkg::PC_W'(data_len + consts_len);

	logic [sf_pkg::PC_W-1:0] pc_q;
	logic step;
	logic run_q;
	logic choose_const;
	logic signed [pw-1:0] sample_q;
	logic [sf_pkg::INST_W-1:0] rom_d;
	logic [sf_pkg::INST_W-1:0] inst_q;
	logic sat_happened;
	logic [6:0] sat_cnt_q;

	// pc parks at the last address
	assign step = ~(&pc_q);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_q <= '1;
			run_q <= 1'b0;
			trace_strobe_o <= 1'b0;
		end else if (ce_i) begin
			if (trigger_i) begin
				pc_q <= '0;
			end else begin
				pc_q <= pc_q + sf_pkg::PC_W'(step);
			end
			// trigger wins over the stall
			if (trigger_i) begin
				run_q <= 1'b1;
			end else if (!step) begin
				run_q <= 1'b0;
			end
			trace_strobe_o <= run_q;
		end
	end

	assign trace_addr_o = pc_q;

	// read one address ahead, memory adds one cycle
	assign const_addr_o = const_aw'(pc_q + sf_pkg::PC_W'(1) - CONST_LO);

	// samples first, then host constants
	assign choose_const = (pc_q >= CONST_LO) && (pc_q < CONST_HI);

	always_ff @(posedge clk) begin
		if (ce_i) begin
			sample_q <= choose_const ? const_data_i : meas_i;
		end
	end

	// program ROM
	always_comb begin
		case (pc_q)
`include "sf_ops.svh"
		endcase
	end

	// registered ROM word, arrives with the sample picked at the same pc
	always_ff @(posedge clk) begin
		if (rst_i) begin
			inst_q <= '0;
		end else if (ce_i) begin
			inst_q <= rom_d;
		end
	end

	sf_engine #(
		.pw(pw),
		.extra(extra),
		.mw(mw)
	) u_sf_engine (
		.clk(clk),
		.rst_i(rst_i),
		.ce_i(ce_i),
		.inst_i(inst_q),
		.meas_i(sample_q),
		.a_o(a_o),
		.b_o(b_o),
		.c_o(c_o),
		.d_o(d_o),
		.trace_o(trace_o),
		.sat_happened_o(sat_happened)
	);

	// clip count per pass, reported at the following trigger
	always_ff @(posedge clk) begin
		if (rst_i) begin
			sat_cnt_q <= '0;
			sat_count_o <= '0;
		end else if (ce_i) begin
			if (trigger_i) begin
				sat_cnt_q <= '0;
				sat_count_o <= sat_cnt_q;
			end else begin
				sat_cnt_q <= sat_cnt_q + 7'(sat_happened);
			end
		end
	end

	// a new pass must not cut into the constant reads
	a_no_trig_in_consts: assert property (@(posedge clk) disable iff (rst_i)
		(ce_i && trigger_i) |-> !choose_const);

endmodule

// File: sf_top.sv
`timescale 1ns/1ps

module sf_top #(
	parameter int pw = 18,
	parameter int extra = 4,
	// needs pw + extra >= mw
	parameter int mw = 18,
	parameter int data_len = 6,
	parameter int consts_len = 4,
	parameter int const_aw = 2
) (
	input logic clk,
	input logic rst_i,
	input logic ce_i,
	// host constant writes
	input logic host_we_i,
	input logic [const_aw-1:0] host_addr_i,
	input logic signed [pw-1:0] host_data_i,
	// measurement stream
	input logic signed [pw-1:0] meas_i,
	input logic trigger_i,
	// results
	output logic signed [pw-1:0] a_o,
	output logic signed [pw-1:0] b_o,
	output logic signed [pw-1:0] c_o,
	output logic signed [pw-1:0] d_o,
	// debug
	output logic signed [pw+extra-1:0] trace_o,
	output logic [sf_pkg::PC_W-1:0] trace_addr_o,
	output logic trace_strobe_o,
	output logic [6:0] sat_count_o
);

	logic [const_aw-1:0] const_addr;
	logic signed [pw-1:0] const_data;

	sf_const_ram #(
		.pw(pw),
		.const_aw(const_aw)
	) u_sf_const_ram (
		.clk(clk),
		.rst_i(rst_i),
		.host_we_i(host_we_i),
		.host_addr_i(host_addr_i),
		.host_data_i(host_data_i),
		.ce_i(ce_i),
		.rd_addr_i(const_addr),
		.rd_data_o(const_data)
	);

	sf_sequencer #(
		.pw(pw),
		.extra(extra),
		.mw(mw),
		.data_len(data_len),
		.consts_len(consts_len),
		.const_aw(const_aw)
	) u_sf_sequencer (
		.clk(clk),
		.rst_i(rst_i),
		.ce_i(ce_i),
		.meas_i(meas_i),
		.trigger_i(trigger_i),
		.const_data_i(const_data),
		.const_addr_o(const_addr),
		.a_o(a_o),
		.b_o(b_o),
		.c_o(c_o),
		.d_o(d_o),
		.trace_o(trace_o),
		.trace_addr_o(trace_addr_o),
		.trace_strobe_o(trace_strobe_o),
		.sat_count_o(sat_count_o)
	);

endmodule

// File: tb_sf_top.sv
`timescale 1ns/1ps

module tb_sf_top;

	// design sizes, same values the top level defaults to
	localparam int pw = 18;
	localparam int extra = 4;
	localparam int mw = 18;
	localparam int data_len = 6;
	localparam int consts_len = 4;
	localparam int const_aw = 2;
	// register width inside the engine
	localparam int rw = pw + extra;
	// four directed cases, then random ones
	localparam int n_fix = 4;
	localparam int n_case = 8;
	localparam int timeout_cyc = (n_case + 2) * 140;

	logic clk;
	logic rst_i;
	logic ce_i;
	logic host_we_i;
	logic [const_aw-1:0] host_addr_i;
	logic signed [pw-1:0] host_data_i;
	logic signed [pw-1:0] meas_i;
	logic trigger_i;
	logic signed [pw-1:0] a_o;
	logic signed [pw-1:0] b_o;
	logic signed [pw-1:0] c_o;
	logic signed [pw-1:0] d_o;
	logic signed [pw+extra-1:0] trace_o;
	logic [6:0] trace_addr_o;
	logic trace_strobe_o;
	logic [6:0] sat_count_o;

	// directed rows: small values, full scale, new constants, ce gap
	int fix_smp [n_fix][6] = '{
		'{1000, 2000, 5000, 300, -700, 400},
		'{131071, 131071, 1000, 2000, 131071, 131071},
		'{1000, 2000, 5000, 300, -700, 400},
		'{1000, 2000, 5000, 300, -700, 400}
	};
	int fix_const [n_fix][4] = '{
		'{65536, 32768, 16384, 100},
		'{131071, 4096, 131071, -131072},
		'{-40000, 98304, -8192, -2500},
		'{65536, 32768, 16384, 100}
	};
	bit fix_gap [n_fix] = '{1'b0, 1'b0, 1'b0, 1'b1};

	// case table, expected columns filled by the model
	int smp_tab [n_case][6];
	int const_tab [n_case][4];
	bit gap_tab [n_case];
	int exp_tab [n_case][4];
	int exp_sat [n_case];
	int exp_trace [n_case];

	logic [31:0] rng_state;
	int cycle_cnt = 0;

	sf_top #(
		.pw(pw),
		.extra(extra),
		.mw(mw),
		.data_len(data_len),
		.consts_len(consts_len),
		.const_aw(const_aw)
	) u_sf_top (
		.clk(clk),
		.rst_i(rst_i),
		.ce_i(ce_i),
		.host_we_i(host_we_i),
		.host_addr_i(host_addr_i),
		.host_data_i(host_data_i),
		.meas_i(meas_i),
		.trigger_i(trigger_i),
		.a_o(a_o),
		.b_o(b_o),
		.c_o(c_o),
		.d_o(d_o),
		.trace_o(trace_o),
		.trace_addr_o(trace_addr_o),
		.trace_strobe_o(trace_strobe_o),
		.sat_count_o(sat_count_o)
	);

	// 40 ns clock
	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_val(input string name, input int got, input int exp);
		assert (got == exp) else begin
			stop_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	// guard against a DUT that never drops its strobe
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= timeout_cyc) begin
			stop_run($sformatf("timeout: run still busy after %0d cycles", timeout_cyc));
		end
	end

	// one clock, then the drive point 2 ns after the edge
	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// signed n-bit limits
	function automatic longint clip_to(input longint v, input int n);
		longint lim;
		lim = longint'(1) <<< (n - 1);
		if (v > lim - 1) begin
			return lim - 1;
		end
		if (v < -lim) begin
			return -lim;
		end
		return v;
	endfunction

	task automatic sat_to(input longint v, input int n, output longint r, inout int cnt);
		r = clip_to(v, n);
		if (r != v) begin
			cnt++;
		end
	endtask

	// fractional multiply: operands limited to mw, drop mw-1 bits, limit to rw
	task automatic frac_mul(input longint x, input longint y, output longint r, inout int cnt);
		longint mx;
		longint my;
		longint pr;
		mx = clip_to(x, mw);
		my = clip_to(y, mw);
		pr = (mx * my) >>> (mw - 1);
		r = clip_to(pr, rw);
		// a multiply counts once however many stages clip
		if (mx != x || my != y || r != pr) begin
			cnt++;
		end
	endtask

	// reference for the filter program, results and clip events of one pass
	task automatic run_model(input int i);
		longint m [6];
		longint k [4];
		longint t;
		longint p_a;
		longint p_c;
		longint p_d;
		longint s_a;
		longint s_b;
		longint s_d;
		longint res [4];
		int cnt;
		cnt = 0;
		for (int j = 0; j < 6; j++) begin
			m[j] = longint'(smp_tab[i][j]);
		end
		for (int j = 0; j < 4; j++) begin
			k[j] = longint'(const_tab[i][j]);
		end
		sat_to(m[4] + m[5], rw, t, cnt);
		frac_mul(m[0], k[0], p_a, cnt);
		frac_mul(m[4], k[1], p_c, cnt);
		frac_mul(t, k[2], p_d, cnt);
		sat_to(p_d - k[3], rw, s_d, cnt);
		sat_to(p_a + m[1], rw, s_a, cnt);
		sat_to(m[2] - m[3], rw, s_b, cnt);
		// results are narrowed to pw
		sat_to(s_a, pw, res[0], cnt);
		sat_to(s_b, pw, res[1], cnt);
		sat_to(p_c, pw, res[2], cnt);
		sat_to(s_d, pw, res[3], cnt);
		for (int j = 0; j < 4; j++) begin
			exp_tab[i][j] = int'(res[j]);
		end
		// m2 - m3 is the last register write of the program
		exp_trace[i] = int'(s_b);
		exp_sat[i] = cnt;
	endtask

	task automatic build_table();
		logic signed [pw-1:0] r_val;
		rng_state = 32'd43;
		for (int i = 0; i < n_case; i++) begin
			for (int j = 0; j < 6; j++) begin
				if (i < n_fix) begin
					smp_tab[i][j] = fix_smp[i][j];
				end else begin
					rng_state = xorshift32(rng_state);
					r_val = rng_state[pw-1:0];
					smp_tab[i][j] = int'(r_val);
				end
			end
			for (int j = 0; j < 4; j++) begin
				if (i < n_fix) begin
					const_tab[i][j] = fix_const[i][j];
				end else begin
					rng_state = xorshift32(rng_state);
					r_val = rng_state[pw-1:0];
					const_tab[i][j] = int'(r_val);
				end
			end
			gap_tab[i] = (i < n_fix) ? fix_gap[i] : 1'b0;
			run_model(i);
		end
	endtask

	// one full pass: constants, trigger, samples, wait for the strobe to drop
	task automatic apply_case(input int i, input int prev_sat);
		int pc_exp;
		int hi_cnt;
		int iter;
		bit seen_hi;
		for (int k = 0; k < consts_len; k++) begin
			host_we_i = 1'b1;
			host_addr_i = const_aw'(k);
			host_data_i = pw'(const_tab[i][k]);
			tick();
		end
		host_we_i = 1'b0;
		trigger_i = 1'b1;
		tick();
		trigger_i = 1'b0;
		// count of the previous pass shows up at this trigger
		check_val("sat_count_o", int'(sat_count_o), prev_sat);
		pc_exp = 0;
		hi_cnt = 0;
		iter = 0;
		seen_hi = 1'b0;
		while (!(seen_hi && !trace_strobe_o)) begin
			check_val("trace_addr_o", int'(trace_addr_o), pc_exp);
			// sample held until pc moves on, so a ce gap keeps it in place
			meas_i = (pc_exp < data_len) ? pw'(smp_tab[i][pc_exp]) : '0;
			ce_i = !(gap_tab[i] && iter >= 3 && iter < 7);
			if (trace_strobe_o) begin
				seen_hi = 1'b1;
				if (ce_i) begin
					hi_cnt++;
				end
			end
			tick();
			if (ce_i && pc_exp < 127) begin
				pc_exp++;
			end
			iter++;
		end
		ce_i = 1'b1;
		check_val("trace_strobe_o high cycles", hi_cnt, 128);
		check_val("a_o", int'(a_o), exp_tab[i][0]);
		check_val("b_o", int'(b_o), exp_tab[i][1]);
		check_val("c_o", int'(c_o), exp_tab[i][2]);
		check_val("d_o", int'(d_o), exp_tab[i][3]);
		check_val("trace_o", int'(trace_o), exp_trace[i]);
	endtask

	initial begin
		rst_i = 1'b1;
		ce_i = 1'b1;
		host_we_i = 1'b0;
		host_addr_i = '0;
		host_data_i = '0;
		meas_i = '0;
		trigger_i = 1'b0;
		build_table();
		repeat (5) tick();
		rst_i = 1'b0;
		tick();
		// idle state straight after reset
		check_val("a_o", int'(a_o), 0);
		check_val("b_o", int'(b_o), 0);
		check_val("c_o", int'(c_o), 0);
		check_val("d_o", int'(d_o), 0);
		check_val("trace_strobe_o", int'(trace_strobe_o), 0);
		check_val("sat_count_o", int'(sat_count_o), 0);
		check_val("trace_addr_o", int'(trace_addr_o), 127);
		for (int i = 0; i < n_case; i++) begin
			apply_case(i, (i == 0) ? 0 : exp_sat[i-1]);
		end
		// extra trigger to read out the last pass count
		trigger_i = 1'b1;
		tick();
		trigger_i = 1'b0;
		check_val("sat_count_o", int'(sat_count_o), exp_sat[n_case-1]);
		$display("Test passed");
		$finish;
	end

endmodule

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_sf_top
FLIST ?= flist.f
FLAGS ?= --binary --timing --assert
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: flist.f
+incdir+.
sf_pkg.sv
sf_const_ram.sv
sf_engine.sv
sf_sequencer.sv
sf_top.sv
tb_sf_top.sv
